// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - source/icache_pkg.sv
      - source/icache_line_ram.sv
      - source/icache_tag_array.sv
      - source/icache.sv
      - source/fetch_unit.sv
      - source/icache_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/icache_props.sv
      - test/icache_checker.sv
      - test/icache_tb.sv

// ==== build.f ====
source/icache_pkg.sv
source/icache_line_ram.sv
source/icache_tag_array.sv
source/icache.sv
source/fetch_unit.sv
source/icache_top.sv
test/tb_clock.sv
test/icache_props.sv
test/icache_checker.sv
test/icache_tb.sv

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          redirect_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                          req_valid_o,
  input  logic                          req_ready_i,
  output icache_pkg::fetch_req_t        req_o,
  input  logic                          rsp_valid_i,
  output logic                          rsp_ready_o,
  input  icache_pkg::fetch_rsp_t        rsp_i,
  output logic                          insn_valid_o,
  input  logic                          insn_ready_i,
  output icache_pkg::fetch_insn_t       insn_o
);
  import icache_pkg::*;

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] next_pc;
  logic [ADDR_W-1:0] req_pc_q;
  logic              epoch_q;
  logic              epoch_next;
  logic              req_epoch_q;
  logic              req_valid_q;
  logic              out_valid_q;
  fetch_insn_t       queue_q [2];
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        count_q;
  logic [1:0]        count_next;
  logic              req_fire;
  logic              rsp_fire;
  logic              push;
  logic              pop;
  logic              pend_next;
  logic              out_next;
  logic              issue;

  assign req_fire    = req_valid_q & req_ready_i;
  assign rsp_fire    = rsp_valid_i & rsp_ready_o;
  assign rsp_ready_o = (count_q != 2'd2);
  // old epoch words are taken and dropped
  assign push        = rsp_fire & (req_epoch_q == epoch_q) & ~redirect_valid_i;
  assign pop         = insn_valid_o & insn_ready_i;

  assign next_pc    = redirect_valid_i ? {redirect_pc_i[ADDR_W-1:3], 3'b000} : pc_q;
  assign epoch_next = epoch_q ^ redirect_valid_i;
  assign count_next = redirect_valid_i ? 2'd0 : count_q + 2'(push) - 2'(pop);
  assign pend_next  = req_valid_q & ~req_fire;
  assign out_next   = (out_valid_q & ~rsp_fire) | req_fire;
  // a slot must stay free for the word in flight
  assign issue      = ~pend_next & ~out_next & (count_next < 2'd2);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= '0;
      epoch_q     <= 1'b0;
      req_valid_q <= 1'b0;
      out_valid_q <= 1'b0;
      count_q     <= 2'd0;
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
    end else begin
      epoch_q     <= epoch_next;
      req_valid_q <= pend_next | issue;
      out_valid_q <= out_next;
      count_q     <= count_next;
      pc_q        <= issue ? next_pc + ADDR_W'(8) : next_pc;
      if (redirect_valid_i) begin
        wr_ptr_q <= 1'b0;   // flush
        rd_ptr_q <= 1'b0;
      end else begin
        if (push) wr_ptr_q <= ~wr_ptr_q;
        if (pop) rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_q    <= next_pc;
      req_epoch_q <= epoch_next;
    end
    if (push) begin
      queue_q[wr_ptr_q] <= '{pc: req_pc_q, data: rsp_i.data, fault: (rsp_i.resp == ERR)};
    end
  end

  assign req_valid_o  = req_valid_q;
  assign req_o        = '{addr: req_pc_q};
  assign insn_valid_o = (count_q != 2'd0);
  assign insn_o       = queue_q[rd_ptr_q];

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps

module icache (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output icache_pkg::fetch_rsp_t rsp_o,
  output icache_pkg::mem_ar_t    mem_ar_o,
  input  logic                   mem_ar_ready_i,
  input  icache_pkg::mem_r_t     mem_r_i,
  output logic                   mem_r_ready_o
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_HIT,
    S_AR,
    S_RD
  } state_e;

  state_e                   state_q;
  cache_addr_t              req_addr;
  cache_addr_t              addr_q;
  logic                     way_q;
  logic                     hit;
  logic                     hit_way;
  logic                     victim;
  logic [INDEX_W-1:0]       ram_addr;
  logic [LINE_W-1:0]        ram_q [WAYS];
  logic [$clog2(BEATS)-1:0] beat_q;
  logic                     err_q;
  logic                     rsp_valid_q;
  fetch_rsp_t               rsp_q;
  logic                     ar_valid_q;
  logic                     req_fire;
  logic                     ar_fire;
  logic                     r_fire;
  logic                     last_beat;
  logic                     beat_err;

  assign req_addr    = req_i.addr;
  assign req_ready_o = (state_q == S_IDLE);   // one request in flight
  assign req_fire    = req_valid_i & req_ready_o;
  assign ar_fire     = ar_valid_q & mem_ar_ready_i;

  assign mem_r_ready_o = (state_q == S_RD);
  assign r_fire        = mem_r_i.valid & mem_r_ready_o;
  assign last_beat     = (beat_q == $clog2(BEATS)'(BEATS - 1));
  assign beat_err      = (mem_r_i.resp == ERR);

  // line is read with the incoming index while idle
  assign ram_addr = (state_q == S_IDLE) ? req_addr.index : addr_q.index;

  icache_tag_array u_tags (
    .clk          (clk),
    .rst          (rst),
    .lookup_i     (req_addr),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_o     (victim),
    .alloc_i      (ar_fire),
    .alloc_addr_i (addr_q),
    .alloc_way_i  (way_q),
    .fill_done_i  (r_fire & last_beat),
    .fill_ok_i    (~(err_q | beat_err))
  );

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    icache_line_ram u_ram (
      .clk     (clk),
      .addr_i  (ram_addr),
      .we_i    (r_fire & (way_q == 1'(w))),
      .half_i  (beat_q[0]),   // lower half arrives first
      .wdata_i (mem_r_i.data),
      .rdata_o (ram_q[w])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      rsp_valid_q <= 1'b0;
      ar_valid_q  <= 1'b0;
      beat_q      <= '0;
      err_q       <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req_fire) begin
            if (hit) begin
              state_q <= S_HIT;
            end else begin
              state_q    <= S_AR;
              ar_valid_q <= 1'b1;
            end
          end
        end
        S_HIT: begin
          if (!rsp_valid_q) begin
            rsp_valid_q <= 1'b1;   // line read is ready now
          end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
            state_q     <= S_IDLE;
          end
        end
        S_AR: begin
          if (ar_fire) begin
            ar_valid_q <= 1'b0;
            beat_q     <= '0;
            err_q      <= 1'b0;
            state_q    <= S_RD;
          end
        end
        S_RD: begin
          if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= err_q | beat_err;
            if (last_beat) begin
              rsp_valid_q <= 1'b1;   // word already captured, skip the ram
              state_q     <= S_HIT;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= req_addr;
      way_q  <= hit ? hit_way : victim;
    end
    if (state_q == S_HIT && !rsp_valid_q) begin
      rsp_q.data <= addr_q.offset[3] ? ram_q[way_q][LINE_W-1:DATA_W]
                                     : ram_q[way_q][DATA_W-1:0];
      rsp_q.resp <= OKAY;
    end else if (r_fire) begin
      if (beat_q == addr_q.offset[3]) begin
        rsp_q.data <= mem_r_i.data;   // beat for the requested word
      end
      if (last_beat) begin
        rsp_q.resp <= (err_q | beat_err) ? ERR : OKAY;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // line aligned burst of two beats
  assign mem_ar_o = '{valid: ar_valid_q,
                      addr:  {addr_q.tag, addr_q.index, {OFFSET_W{1'b0}}},
                      len:   8'(BEATS - 1)};

endmodule

// ==== source/icache_line_ram.sv ====
`timescale 1ns/1ps

module icache_line_ram (
  input  logic                           clk,
  input  logic [icache_pkg::INDEX_W-1:0] addr_i,
  input  logic                           we_i,
  input  logic                           half_i,
  input  logic [icache_pkg::DATA_W-1:0]  wdata_i,
  output logic [icache_pkg::LINE_W-1:0]  rdata_o
);
  import icache_pkg::*;

  logic [LINE_W-1:0] mem_q [SETS];

  // half-line write, refill beats land one at a time
  always_ff @(posedge clk) begin
    if (we_i) begin
      if (half_i) begin
        mem_q[addr_i][LINE_W-1:DATA_W] <= wdata_i;   // upper word
      end else begin
        mem_q[addr_i][DATA_W-1:0] <= wdata_i;        // lower word
      end
    end
  end

  // registered read of the whole line
  always_ff @(posedge clk) begin
    rdata_o <= mem_q[addr_i];
  end

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

  // address and data sizes
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;

  // 22/6/4 split of a physical address
  localparam int TAG_W    = 22;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 4;

  localparam int SETS     = 64;
  localparam int WAYS     = 2;
  localparam int LINE_W   = 128;   // two fetch words per line
  localparam int BEATS    = 2;     // refill beats per line

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;   // bit 3 picks the half line
  } cache_addr_t;

  typedef enum logic [1:0] {
    OKAY = 2'b00,
    ERR  = 2'b10
  } resp_e;

  // fetch unit to cache
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  // cache to fetch unit
  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } fetch_rsp_t;

  // refill request, len is beats minus one
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } mem_ar_t;

  typedef struct packed {
    logic              valid;
    resp_e             resp;
    logic [DATA_W-1:0] data;
  } mem_r_t;

  // word handed to the consumer
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] data;
    logic              fault;
  } fetch_insn_t;

endpackage

// ==== source/icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::cache_addr_t lookup_i,
  output logic                    hit_o,
  output logic                    hit_way_o,
  output logic                    victim_o,
  input  logic                    alloc_i,
  input  icache_pkg::cache_addr_t alloc_addr_i,
  input  logic                    alloc_way_i,
  input  logic                    fill_done_i,
  input  logic                    fill_ok_i
);
  import icache_pkg::*;

  logic [TAG_W-1:0] tag_q [WAYS][SETS];
  logic [SETS-1:0]  valid_q [WAYS];
  logic [WAYS-1:0]  way_hit;
  logic             victim_q;

  // compare both ways against the incoming address
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[w][lookup_i.index] &&
                   (tag_q[w][lookup_i.index] == lookup_i.tag);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];   // way 0 unless way 1 hits
  assign victim_o  = victim_q;

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      tag_q[alloc_way_i][alloc_addr_i.index] <= alloc_addr_i.tag;
    end
  end

  // line stays invalid until a clean refill completes
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else if (alloc_i) begin
      valid_q[alloc_way_i][alloc_addr_i.index] <= 1'b0;
    end else if (fill_done_i && fill_ok_i) begin
      valid_q[alloc_way_i][alloc_addr_i.index] <= 1'b1;
    end
  end

  // round robin victim, free running
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= 1'b0;
    end else begin
      victim_q <= ~victim_q;
    end
  end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          redirect_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                          insn_valid_o,
  input  logic                          insn_ready_i,
  output icache_pkg::fetch_insn_t       insn_o,
  output icache_pkg::mem_ar_t           mem_ar_o,
  input  logic                          mem_ar_ready_i,
  input  icache_pkg::mem_r_t            mem_r_i,
  output logic                          mem_r_ready_o
);
  import icache_pkg::*;

  // fetch unit to cache channels
  logic       req_valid;
  logic       req_ready;
  fetch_req_t req;
  logic       rsp_valid;
  logic       rsp_ready;
  fetch_rsp_t rsp;

  fetch_unit u_fetch (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_valid_o      (req_valid),
    .req_ready_i      (req_ready),
    .req_o            (req),
    .rsp_valid_i      (rsp_valid),
    .rsp_ready_o      (rsp_ready),
    .rsp_i            (rsp),
    .insn_valid_o     (insn_valid_o),
    .insn_ready_i     (insn_ready_i),
    .insn_o           (insn_o)
  );

  icache u_icache (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_i          (req),
    .rsp_valid_o    (rsp_valid),
    .rsp_ready_i    (rsp_ready),
    .rsp_o          (rsp),
    .mem_ar_o       (mem_ar_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_r_i        (mem_r_i),
    .mem_r_ready_o  (mem_r_ready_o)
  );

endmodule

// ==== test/icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker #(
  parameter logic [31:0] ERR_LO = 32'h0000_8000,
  parameter logic [31:0] ERR_HI = 32'h0000_803f,
  parameter int          NAME_W = 96
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [NAME_W-1:0]             test_name_i,
  input  logic                          redirect_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                          insn_valid_i,
  input  logic                          insn_ready_i,
  input  icache_pkg::fetch_insn_t       insn_i,
  input  icache_pkg::mem_ar_t           ar_i,
  input  logic                          ar_ready_i,
  input  icache_pkg::mem_r_t            r_i,
  input  logic                          r_ready_i,
  input  logic                          done_i,
  output int                            errors_o,
  output int                            words_o,
  output int                            refills_o
);
  import icache_pkg::*;

  localparam int LINES = 4096;   // lines of the low 64 KiB

  logic [ADDR_W-1:0] exp_pc;
  logic              exp_valid;
  int                clean_at [LINES];   // set refill count at last clean fill, -1 if none
  bit                err_seen [LINES];
  int                idx_cnt [SETS];
  logic [11:0]       fill_line;
  int                beat;
  bit                fill_err;
  int                evict_refills;
  int                err_refetches;
  bit                closed;

  function automatic string name_str(input logic [NAME_W-1:0] raw);
    string s;
    s = "";
    for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
      if (raw[i*8 +: 8] != 8'h00) s = {s, $sformatf("%c", raw[i*8 +: 8])};
    end
    return s;
  endfunction

  always @(posedge clk) begin : watch
    logic [11:0] line;
    logic        exp_fault;
    if (rst) begin
      for (int i = 0; i < LINES; i++) begin
        clean_at[i] = -1;
        err_seen[i] = 1'b0;
      end
      for (int i = 0; i < SETS; i++) idx_cnt[i] = 0;
      exp_valid     = 1'b0;
      beat          = 0;
      fill_err      = 1'b0;
      evict_refills = 0;
      err_refetches = 0;
      closed        = 1'b0;
      errors_o      = 0;
      words_o       = 0;
      refills_o     = 0;
    end else begin
      if (insn_valid_i && insn_ready_i) begin
        words_o++;
        if (!exp_valid) begin
          errors_o++;
          $display("instruction at pc %h delivered before any redirect", insn_i.pc);
        end else begin
          exp_fault = (exp_pc >= ERR_LO) && (exp_pc <= ERR_HI);
          if (insn_i.pc !== exp_pc) begin
            errors_o++;
            $display("[FAIL] %s pc: expected %h, actual %h",
                     name_str(test_name_i), exp_pc, insn_i.pc);
          end
          if (insn_i.fault !== exp_fault) begin
            errors_o++;
            $display("[FAIL] %s fault at %h: expected %b, actual %b",
                     name_str(test_name_i), exp_pc, exp_fault, insn_i.fault);
          end
          // memory rule, word is its address and the inverse
          if (!exp_fault && insn_i.data !== {exp_pc, ~exp_pc}) begin
            errors_o++;
            $display("[FAIL] %s data at %h: expected %h, actual %h",
                     name_str(test_name_i), exp_pc, {exp_pc, ~exp_pc}, insn_i.data);
          end
          exp_pc = exp_pc + 32'd8;
        end
      end
      if (redirect_valid_i) begin
        exp_pc    = {redirect_pc_i[ADDR_W-1:3], 3'b000};
        exp_valid = 1'b1;
      end

      if (ar_i.valid && ar_ready_i) begin
        refills_o++;
        line = ar_i.addr[15:4];
        if (ar_i.addr[31:16] != '0 || ar_i.addr[3:0] != '0 || ar_i.len != 8'd1) begin
          errors_o++;
          $display("bad refill request: addr %h len %0d", ar_i.addr, ar_i.len);
        end
        if (err_seen[line]) begin
          err_refetches++;   // line was left invalid
          err_seen[line] = 1'b0;
        end else if (clean_at[line] >= 0) begin
          if (clean_at[line] == idx_cnt[line[5:0]]) begin
            errors_o++;
            $display("line %h refilled again although nothing could have evicted it",
                     ar_i.addr);
          end else begin
            evict_refills++;
          end
        end
        idx_cnt[line[5:0]]++;
        clean_at[line] = -1;
        fill_line      = line;
        fill_err       = 1'b0;
        beat           = 0;
      end
      if (r_i.valid && r_ready_i) begin
        fill_err = fill_err | (r_i.resp == ERR);
        beat++;
        if (beat == BEATS) begin
          if (fill_err) err_seen[fill_line] = 1'b1;
          else clean_at[fill_line] = idx_cnt[fill_line[5:0]];
        end
      end

      if (done_i && !closed) begin
        closed = 1'b1;
        if (evict_refills == 0) begin
          errors_o++;
          $display("no line was refilled after an eviction by a set conflict");
        end
        if (err_refetches == 0) begin
          errors_o++;
          $display("a line left invalid by an error response was never refetched");
        end
      end
    end
  end

endmodule

// ==== test/icache_props.sv ====
`timescale 1ns/1ps

module icache_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   req_ready_i,
  input logic                   rsp_valid_i,
  input logic                   rsp_ready_i,
  input icache_pkg::fetch_rsp_t rsp_i,
  input icache_pkg::mem_ar_t    ar_i,
  input logic                   ar_ready_i
);

  int fail_count = 0;

  // refill request held with a steady address until taken
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_i.valid && !ar_ready_i |=> ar_i.valid && $stable(ar_i.addr))
    else begin
      $error("refill request dropped or changed before mem_ar_ready_i");
      fail_count++;
    end

  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      $error("response dropped or changed before rsp_ready");
      fail_count++;
    end

  // one request in flight
  no_accept: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i |-> !req_ready_i)
    else begin
      $error("cache ready for a request while a response is pending");
      fail_count++;
    end

endmodule

bind icache icache_props u_props (
  .clk         (clk),
  .rst         (rst),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_i       (rsp_o),
  .ar_i        (mem_ar_o),
  .ar_ready_i  (mem_ar_ready_i)
);

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int                NUM_TESTS = 14;
  localparam int                NAME_W    = 96;
  localparam logic [ADDR_W-1:0] ERR_LO    = 32'h0000_8000;   // refills here answer ERR
  localparam logic [ADDR_W-1:0] ERR_HI    = 32'h0000_803f;

  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic [ADDR_W-1:0] pc;
    logic [7:0]        words;   // words the consumer takes
    logic [7:0]        stall;   // set bit holds insn_ready low that cycle
  } test_t;

  logic              clk;
  logic              rst;
  logic              redirect_valid;
  logic [ADDR_W-1:0] redirect_pc;
  logic              insn_valid;
  logic              insn_ready;
  fetch_insn_t       insn;
  mem_ar_t           mem_ar;
  logic              mem_ar_ready;
  mem_r_t            mem_r;
  logic              mem_r_ready;
  logic [NAME_W-1:0] test_name;
  logic              done;
  int                errors;
  int                words;
  int                refills;
  test_t             tests [NUM_TESTS];

  tb_clock u_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  icache_top DUT (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .insn_valid_o     (insn_valid),
    .insn_ready_i     (insn_ready),
    .insn_o           (insn),
    .mem_ar_o         (mem_ar),
    .mem_ar_ready_i   (mem_ar_ready),
    .mem_r_i          (mem_r),
    .mem_r_ready_o    (mem_r_ready)
  );

  icache_checker #(
    .ERR_LO (ERR_LO),
    .ERR_HI (ERR_HI),
    .NAME_W (NAME_W)
  ) u_checker (
    .clk              (clk),
    .rst              (rst),
    .test_name_i      (test_name),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .insn_valid_i     (insn_valid),
    .insn_ready_i     (insn_ready),
    .insn_i           (insn),
    .ar_i             (mem_ar),
    .ar_ready_i       (mem_ar_ready),
    .r_i              (mem_r),
    .r_ready_i        (mem_r_ready),
    .done_i           (done),
    .errors_o         (errors),
    .words_o          (words),
    .refills_o        (refills)
  );

  function automatic logic [DATA_W-1:0] beat_word(input logic [ADDR_W-1:0] addr);
    return {addr, ~addr};
  endfunction

  task automatic load_table();
    tests[0]  = '{"seq_first",  32'h0000_1000, 8'd16, 8'h00};   // cold pass over 8 lines
    tests[1]  = '{"seq_again",  32'h0000_1000, 8'd16, 8'h00};
    tests[2]  = '{"backpress",  32'h0000_1008, 8'd12, 8'hb6};
    tests[3]  = '{"conflict_a", 32'h0000_2200, 8'd2,  8'h00};   // same index 0x20
    tests[4]  = '{"conflict_b", 32'h0000_2600, 8'd2,  8'h00};
    tests[5]  = '{"conflict_c", 32'h0000_2a00, 8'd2,  8'h00};
    tests[6]  = '{"conflict_a", 32'h0000_2200, 8'd2,  8'h09};
    tests[7]  = '{"conflict_b", 32'h0000_2600, 8'd2,  8'h00};
    tests[8]  = '{"conflict_c", 32'h0000_2a00, 8'd2,  8'h00};
    tests[9]  = '{"redir_mid",  32'h0000_1014, 8'd3,  8'h00};   // unaligned target
    tests[10] = '{"err_line",   32'h0000_8000, 8'd3,  8'h05};
    tests[11] = '{"err_again",  32'h0000_8000, 8'd2,  8'h00};
    tests[12] = '{"after_err",  32'h0000_8040, 8'd4,  8'h02};
    tests[13] = '{"long_run",   32'h0000_3000, 8'd40, 8'h24};
  endtask

  // ready follows the stall pattern until count words are taken
  task automatic consume(input int count, input logic [7:0] stall);
    int taken;
    int cyc;
    taken = 0;
    cyc   = 0;
    while (taken < count) begin
      insn_ready = ~stall[cyc % 8];
      if (insn_ready && insn_valid) taken++;
      cyc++;
      @(negedge clk);
    end
    insn_ready = 1'b0;
  endtask

  task automatic run_watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("timeout after %0d cycles, the instruction stream stopped", cycles);
    $display("Simulation FAILED");
    $finish;
  endtask

  // burst memory takes the address after 1 to 4 cycles
  initial begin : memory_model
    logic [ADDR_W-1:0] line_addr;
    logic              bad;
    void'($urandom(32'hcf75ad81));
    mem_ar_ready = 1'b0;
    mem_r        = '0;
    forever begin
      @(negedge clk);
      if (!rst && mem_ar.valid) begin
        line_addr = mem_ar.addr;
        bad       = (line_addr >= ERR_LO) && (line_addr <= ERR_HI);
        repeat ($urandom_range(4, 1) - 1) @(negedge clk);
        mem_ar_ready = 1'b1;
        @(negedge clk);
        mem_ar_ready = 1'b0;
        for (int b = 0; b < BEATS; b++) begin
          mem_r = '{valid: 1'b1, resp: bad ? ERR : OKAY,
                    data: beat_word(line_addr + ADDR_W'(8 * b))};
          while (!mem_r_ready) @(negedge clk);
          @(negedge clk);   // beat taken on the edge in between
        end
        mem_r = '0;
      end
    end
  end

  initial begin : stimulus
    int limit;
    int assert_fails;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    insn_ready     = 1'b0;
    done           = 1'b0;
    test_name      = '0;
    load_table();
    limit = 2000;
    for (int t = 0; t < NUM_TESTS; t++) limit += 40 * int'(tests[t].words);
    fork
      run_watchdog(limit);
    join_none
    @(negedge clk);
    while (rst) @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_name      = tests[t].name;
      redirect_pc    = tests[t].pc;
      redirect_valid = 1'b1;   // single cycle pulse
      @(negedge clk);
      redirect_valid = 1'b0;
      consume(int'(tests[t].words), tests[t].stall);
    end
    done = 1'b1;
    repeat (3) @(negedge clk);
    assert_fails = DUT.u_icache.u_props.fail_count;
    $display("words checked %0d, refills %0d, errors %0d, assertion failures %0d",
             words, refills, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;   // released on the fourth edge
  end

endmodule
